// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = ctrl_event_unit_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Something failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/ctrl_event_pkg.sv
package ctrl_event_pkg;

  //////////////////////////////////////////////////
  // Data bus limits
  //////////////////////////////////////////////////

  // Most data-bus transactions that may be in flight at once
  // The oldest-of-two selection in the tracker relies on this being 2
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Width of the outstanding counter and of the retire counter
  // Two bits hold the values 0 to 2 for both of them
  localparam int unsigned CNT_W = 2;

  //////////////////////////////////////////////////
  // NMI limits
  //////////////////////////////////////////////////

  // Counted retirements after which a pending NMI is considered overdue
  // The faulting load or store may retire, plus one more instruction
  localparam int unsigned RETIRE_LIMIT = 2;

  //////////////////////////////////////////////////
  // Fence.i handshake states
  //////////////////////////////////////////////////

  // IDLE waits for a fence.i in writeback with an empty write buffer
  // REQ holds the flush request until it is acknowledged
  // DONE waits for the fence.i to leave writeback
  typedef enum logic [1:0] {
    FENCEI_IDLE = 2'b00,
    FENCEI_REQ  = 2'b01,
    FENCEI_DONE = 2'b10
  } fencei_state_e;

endpackage

// File: hdl/ctrl_event_unit.sv
module ctrl_event_unit (
  input  logic                             clk,
  input  logic                             rst_n,
  // Data bus
  input  logic                             bus_req_i,
  input  logic                             bus_gnt_i,
  input  logic                             bus_we_i,
  input  logic                             bus_rvalid_i,
  input  logic                             bus_err_i,
  // Retirement and debug
  input  logic                             wb_valid_i,
  input  logic                             debug_mode_i,
  input  logic                             dcsr_step_i,
  input  logic                             dcsr_stepie_i,
  // NMI entry
  input  logic                             nmi_taken_i,
  // Fence.i
  input  logic                             fencei_in_wb_i,
  input  logic                             fencei_ready_i,
  input  logic                             fencei_flush_ack_i,
  // Status outputs
  output logic [ctrl_event_pkg::CNT_W-1:0] outstanding_cnt_o,
  output logic                             nmi_pending_o,
  output logic                             nmi_is_store_o,
  output logic                             nmi_overdue_o,
  output logic                             fencei_flush_req_o,
  output logic                             fencei_done_o
);

  // Write flag of the transaction answered by the current response
  logic oldest_is_write;

  // Pending NMI, also used to hold off a new flush
  logic nmi_pending;

  // Tracks in-flight bus transactions and their types
  obi_outstanding_tracker obi_outstanding_tracker_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .bus_req_i         (bus_req_i),
    .bus_gnt_i         (bus_gnt_i),
    .bus_we_i          (bus_we_i),
    .bus_rvalid_i      (bus_rvalid_i),
    .outstanding_cnt_o (outstanding_cnt_o),
    .oldest_is_write_o (oldest_is_write)
  );

  // Turns the first bus error into a pending NMI and watches its deadline
  nmi_tracker nmi_tracker_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .bus_rvalid_i      (bus_rvalid_i),
    .bus_err_i         (bus_err_i),
    .oldest_is_write_i (oldest_is_write),
    .nmi_taken_i       (nmi_taken_i),
    .wb_valid_i        (wb_valid_i),
    .debug_mode_i      (debug_mode_i),
    .dcsr_step_i       (dcsr_step_i),
    .dcsr_stepie_i     (dcsr_stepie_i),
    .nmi_pending_o     (nmi_pending),
    .nmi_is_store_o    (nmi_is_store_o),
    .nmi_overdue_o     (nmi_overdue_o)
  );

  // Flush request and acknowledge for fence.i
  fencei_handshake fencei_handshake_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .fencei_in_wb_i     (fencei_in_wb_i),
    .fencei_ready_i     (fencei_ready_i),
    .nmi_pending_i      (nmi_pending),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .fencei_flush_req_o (fencei_flush_req_o),
    .fencei_done_o      (fencei_done_o)
  );

  assign nmi_pending_o = nmi_pending;

endmodule

// File: hdl/fencei_handshake.sv
module fencei_handshake (
  input  logic clk,
  input  logic rst_n,
  input  logic fencei_in_wb_i,
  input  logic fencei_ready_i,
  input  logic nmi_pending_i,
  input  logic fencei_flush_ack_i,
  output logic fencei_flush_req_o,
  output logic fencei_done_o
);

  import ctrl_event_pkg::*;

  fencei_state_e state_q;
  fencei_state_e state_d;

  // Completion pulse, set by the cycle with request and acknowledge
  logic done_q;

  logic start_flush;
  logic req_and_ack;

  // A pending NMI wins over a new flush, the fence.i waits until it is taken
  assign start_flush = fencei_in_wb_i && fencei_ready_i && !nmi_pending_i;

  assign req_and_ack = (state_q == FENCEI_REQ) && fencei_flush_ack_i;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      FENCEI_IDLE: begin
        if (start_flush) begin
          state_d = FENCEI_REQ;
        end
      end
      FENCEI_REQ: begin
        // The request is held for as long as the acknowledge stays low
        if (fencei_flush_ack_i) begin
          state_d = FENCEI_DONE;
        end
      end
      FENCEI_DONE: begin
        // Wait here so the same fence.i does not start a second flush
        if (!fencei_in_wb_i) begin
          state_d = FENCEI_IDLE;
        end
      end
      default: begin
        state_d = FENCEI_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // State and completion registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FENCEI_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= req_and_ack;
    end
  end

  assign fencei_flush_req_o = (state_q == FENCEI_REQ);

  // High only in the first cycle of DONE
  assign fencei_done_o = done_q;

endmodule

// File: hdl/nmi_tracker.sv
module nmi_tracker (
  input  logic clk,
  input  logic rst_n,
  input  logic bus_rvalid_i,
  input  logic bus_err_i,
  input  logic oldest_is_write_i,
  input  logic nmi_taken_i,
  input  logic wb_valid_i,
  input  logic debug_mode_i,
  input  logic dcsr_step_i,
  input  logic dcsr_stepie_i,
  output logic nmi_pending_o,
  output logic nmi_is_store_o,
  output logic nmi_overdue_o
);

  import ctrl_event_pkg::*;

  logic             nmi_pending_q;
  logic             nmi_is_store_q;
  logic [CNT_W-1:0] retire_cnt_q;

  logic bus_error;
  logic retire_counted;
  logic retire_at_limit;

  // An error is only valid together with rvalid
  assign bus_error = bus_rvalid_i && bus_err_i;

  // Retirements in debug mode do not count toward the NMI deadline
  // Neither do steps taken with interrupts masked, since the NMI cannot be taken then
  assign retire_counted = wb_valid_i && !debug_mode_i && !(dcsr_step_i && !dcsr_stepie_i);

  assign retire_at_limit = (retire_cnt_q == CNT_W'(RETIRE_LIMIT));

  //////////////////////////////////////////////////
  // Pending NMI latch
  //////////////////////////////////////////////////

  // Only the first bus error is kept, later ones are dropped until the NMI is taken
  // The store flag keeps its value after the NMI is taken
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      nmi_pending_q  <= 1'b0;
      nmi_is_store_q <= 1'b0;
    end else begin
      if (bus_error && !nmi_pending_q) begin
        nmi_pending_q  <= 1'b1;
        nmi_is_store_q <= oldest_is_write_i;
      end else if (nmi_taken_i) begin
        nmi_pending_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Retire counter
  //////////////////////////////////////////////////

  // Counting starts the cycle after the latch is set
  // The counter saturates at the limit and clears once the latch is gone
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      retire_cnt_q <= '0;
    end else begin
      if (!nmi_pending_q) begin
        retire_cnt_q <= '0;
      end else if (retire_counted && !retire_at_limit) begin
        retire_cnt_q <= retire_cnt_q + CNT_W'(1);
      end
    end
  end

  assign nmi_pending_o  = nmi_pending_q;
  assign nmi_is_store_o = nmi_is_store_q;

  // Overdue as long as the count sits at the limit
  assign nmi_overdue_o = retire_at_limit;

endmodule

// File: hdl/obi_outstanding_tracker.sv
module obi_outstanding_tracker (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             bus_req_i,
  input  logic                             bus_gnt_i,
  input  logic                             bus_we_i,
  input  logic                             bus_rvalid_i,
  output logic [ctrl_event_pkg::CNT_W-1:0] outstanding_cnt_o,
  output logic                             oldest_is_write_o
);

  import ctrl_event_pkg::*;

  // Number of accepted transactions that have not been answered yet
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;

  // Write flags of the outstanding transactions
  // Slot 0 always holds the newest one, slot 1 the older one
  logic [1:0] we_q;
  logic [1:0] we_d;

  logic accept;
  logic resp;
  logic cnt_full;

  // A transaction is accepted when request and grant meet
  assign accept = bus_req_i && bus_gnt_i;

  // Responses come in order, so each rvalid answers the oldest entry
  assign resp = bus_rvalid_i;

  // Both slots are in use
  assign cnt_full = (cnt_q == CNT_W'(MAX_OUTSTANDING));

  //////////////////////////////////////////////////
  // Next count and next flags
  //////////////////////////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    we_d  = we_q;
    if (accept && !resp) begin
      // New transaction on top of the others, shift the older one out of slot 0
      cnt_d = cnt_q + CNT_W'(1);
      we_d  = {we_q[0], bus_we_i};
    end else if (!accept && resp) begin
      // Oldest entry answered
      // With two in flight the survivor already sits in slot 0
      cnt_d = cnt_q - CNT_W'(1);
    end else if (accept && resp) begin
      // Count stays, the new flag replaces the answered entry
      if (cnt_full) begin
        we_d = {we_q[0], bus_we_i};
      end else begin
        we_d = {we_q[1], bus_we_i};
      end
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      we_q  <= '0;
    end else begin
      cnt_q <= cnt_d;
      we_q  <= we_d;
    end
  end

  assign outstanding_cnt_o = cnt_q;

  // Flag of the transaction that the current response answers
  // With one in flight it is the newest slot, with two it is the older slot
  assign oldest_is_write_o = cnt_full ? we_q[1] : we_q[0];

endmodule

// File: list.f
hdl/ctrl_event_pkg.sv
hdl/obi_outstanding_tracker.sv
hdl/nmi_tracker.sv
hdl/fencei_handshake.sv
hdl/ctrl_event_unit.sv
verification/ctrl_event_unit_sva.sv
verification/ctrl_event_unit_tb.sv

// File: verification/ctrl_event_unit_sva.sv
module ctrl_event_unit_sva (
  input logic                             clk,
  input logic                             rst_n,
  input logic [ctrl_event_pkg::CNT_W-1:0] outstanding_cnt_i,
  input logic                             nmi_pending_i,
  input logic                             fencei_in_wb_i,
  input logic                             fencei_flush_ack_i,
  input logic                             fencei_flush_req_i,
  input logic                             fencei_done_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import ctrl_event_pkg::*;

  // The tracker has room for two transactions and no more
  count_limit_a : assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_cnt_i <= CNT_W'(MAX_OUTSTANDING))
    else $error("outstanding count above its limit");

  // The request is only taken back once the flush was acknowledged
  req_drop_a : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(fencei_flush_req_i) |-> $past(fencei_flush_ack_i))
    else $error("flush request dropped without an acknowledge");

  // Completion is a single-cycle pulse
  done_pulse_a : assert property (@(posedge clk) disable iff (!rst_n)
    fencei_done_i |=> !fencei_done_i)
    else $error("fence.i done held longer than one cycle");

  // A flush only makes sense while its fence.i is in writeback
  req_needs_fencei_a : assert property (@(posedge clk) disable iff (!rst_n)
    fencei_flush_req_i |-> fencei_in_wb_i)
    else $error("flush request without a fence.i in writeback");

  // Internal NMI level, a new request may not start on top of it
  nmi_blocks_req_a : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fencei_flush_req_i) |-> !$past(nmi_pending_i))
    else $error("flush request started while an NMI was pending");

endmodule

bind ctrl_event_unit ctrl_event_unit_sva ctrl_event_unit_sva_i (
  .clk                (clk),
  .rst_n              (rst_n),
  .outstanding_cnt_i  (outstanding_cnt_o),
  .nmi_pending_i      (nmi_pending),
  .fencei_in_wb_i     (fencei_in_wb_i),
  .fencei_flush_ack_i (fencei_flush_ack_i),
  .fencei_flush_req_i (fencei_flush_req_o),
  .fencei_done_i      (fencei_done_o)
);

// File: verification/ctrl_event_unit_tb.sv
module ctrl_event_unit_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ctrl_event_pkg::*;

  logic             clk;
  logic             rst_n;
  logic             bus_req;
  logic             bus_gnt;
  logic             bus_we;
  logic             bus_rvalid;
  logic             bus_err;
  logic             wb_valid;
  logic             debug_mode;
  logic             dcsr_step;
  logic             dcsr_stepie;
  logic             nmi_taken;
  logic             fencei_in_wb;
  logic             fencei_ready;
  logic             fencei_flush_ack;
  logic [CNT_W-1:0] outstanding_cnt;
  logic             nmi_pending;
  logic             nmi_is_store;
  logic             nmi_overdue;
  logic             fencei_flush_req;
  logic             fencei_done;

  // Percent chances used by the random driver
  int p_err;
  int p_taken;
  int p_fence;
  int p_ready;
  int p_ack;

  // Reference model, outstanding write flags kept oldest first
  bit            m_flags[$];
  bit            m_pend = 1'b0;
  bit            m_store = 1'b0;
  int            m_ret = 0;
  fencei_state_e m_state = FENCEI_IDLE;
  bit            m_done = 1'b0;

  int    seed;
  int    n;
  string test_name;

  ctrl_event_unit ctrl_event_unit_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .bus_req_i          (bus_req),
    .bus_gnt_i          (bus_gnt),
    .bus_we_i           (bus_we),
    .bus_rvalid_i       (bus_rvalid),
    .bus_err_i          (bus_err),
    .wb_valid_i         (wb_valid),
    .debug_mode_i       (debug_mode),
    .dcsr_step_i        (dcsr_step),
    .dcsr_stepie_i      (dcsr_stepie),
    .nmi_taken_i        (nmi_taken),
    .fencei_in_wb_i     (fencei_in_wb),
    .fencei_ready_i     (fencei_ready),
    .fencei_flush_ack_i (fencei_flush_ack),
    .outstanding_cnt_o  (outstanding_cnt),
    .nmi_pending_o      (nmi_pending),
    .nmi_is_store_o     (nmi_is_store),
    .nmi_overdue_o      (nmi_overdue),
    .fencei_flush_req_o (fencei_flush_req),
    .fencei_done_o      (fencei_done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic bit chance(int pct);
    int r;
    r = $unsigned($random(seed)) % 100;
    return r < pct;
  endfunction

  task automatic check_value(string what, int expected, int actual);
    if (expected != actual) begin
      $display("Error: test %s, %s expected %0d actual %0d", test_name, what, expected, actual);
      $display("Something failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timeout in test %s while waiting for %s", test_name, what);
    $display("Something failed");
    $fatal(1, "Stopped on a timeout");
  endtask

  task automatic set_knobs(int err, int taken, int fence, int ready, int ack);
    p_err   = err;
    p_taken = taken;
    p_fence = fence;
    p_ready = ready;
    p_ack   = ack;
  endtask

  // Random inputs that respect the bus rules of the environment
  task automatic drive_inputs();
    bus_rvalid = (m_flags.size() > 0) && chance(50);
    bus_err    = bus_rvalid && chance(p_err);
    bus_req    = chance(60);
    bus_gnt    = chance(60);
    // A third transaction is only accepted together with a response
    if (m_flags.size() >= int'(MAX_OUTSTANDING) && !bus_rvalid) begin
      bus_gnt = 1'b0;
    end
    bus_we      = chance(50);
    wb_valid    = chance(50);
    debug_mode  = chance(15);
    dcsr_step   = chance(20);
    dcsr_stepie = chance(50);
    nmi_taken   = chance(p_taken);
    // The fence.i stays in writeback while its flush is requested
    fencei_in_wb     = (m_state == FENCEI_REQ) || chance(p_fence);
    fencei_ready     = chance(p_ready);
    fencei_flush_ack = chance(p_ack);
  endtask

  // Applies one rising edge to the model, with the inputs seen at that edge
  task automatic update_model();
    bit oldest;
    bit counted;
    bit pend_before;
    oldest      = (m_flags.size() > 0) ? m_flags[0] : 1'b0;
    counted     = wb_valid && !debug_mode && !(dcsr_step && !dcsr_stepie);
    pend_before = m_pend;
    m_done = (m_state == FENCEI_REQ) && fencei_flush_ack;
    case (m_state)
      FENCEI_IDLE: if (fencei_in_wb && fencei_ready && !pend_before) m_state = FENCEI_REQ;
      FENCEI_REQ:  if (fencei_flush_ack) m_state = FENCEI_DONE;
      default:     if (!fencei_in_wb) m_state = FENCEI_IDLE;
    endcase
    // In-order responses answer the front, accepted ones join at the back
    if (bus_rvalid) void'(m_flags.pop_front());
    if (bus_req && bus_gnt) m_flags.push_back(bus_we);
    if (!pend_before) m_ret = 0;
    else if (counted && m_ret < int'(RETIRE_LIMIT)) m_ret++;
    if (bus_rvalid && bus_err && !pend_before) begin
      m_pend  = 1'b1;
      m_store = oldest;
    end else if (nmi_taken) begin
      m_pend = 1'b0;
    end
  endtask

  task automatic compare_outputs();
    check_value("outstanding_cnt_o", m_flags.size(), int'(outstanding_cnt));
    check_value("nmi_pending_o", int'(m_pend), int'(nmi_pending));
    check_value("nmi_is_store_o", int'(m_store), int'(nmi_is_store));
    check_value("nmi_overdue_o", int'(m_ret == int'(RETIRE_LIMIT)), int'(nmi_overdue));
    check_value("fencei_flush_req_o", int'(m_state == FENCEI_REQ), int'(fencei_flush_req));
    check_value("fencei_done_o", int'(m_done), int'(fencei_done));
  endtask

  // Outputs are compared on the falling edge, where they have settled
  task automatic step_cycle();
    drive_inputs();
    @(posedge clk);
    update_model();
    @(negedge clk);
    compare_outputs();
  endtask

  task automatic settle_fencei();
    set_knobs(0, 0, 0, 70, 100);
    n = 0;
    while (m_state != FENCEI_IDLE && n < 50) begin
      step_cycle();
      n++;
    end
    if (m_state != FENCEI_IDLE) report_timeout("the fence.i FSM to return to idle");
  endtask

  task automatic wait_nmi_level(bit level, string what);
    n = 0;
    while (m_pend != level && n < 200) begin
      step_cycle();
      n++;
    end
    if (m_pend != level) report_timeout(what);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    seed             = 78;
    test_name        = "reset";
    rst_n            = 1'b0;
    bus_req          = 1'b0;
    bus_gnt          = 1'b0;
    bus_we           = 1'b0;
    bus_rvalid       = 1'b0;
    bus_err          = 1'b0;
    wb_valid         = 1'b0;
    debug_mode       = 1'b0;
    dcsr_step        = 1'b0;
    dcsr_stepie      = 1'b0;
    nmi_taken        = 1'b0;
    fencei_in_wb     = 1'b0;
    fencei_ready     = 1'b0;
    fencei_flush_ack = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    compare_outputs();

    // Mixed traffic with rare errors, NMI entries and fence.i flushes
    test_name = "bus_traffic";
    set_knobs(3, 5, 60, 70, 40);
    repeat (300) step_cycle();
    settle_fencei();

    // Later errors are ignored while the first one is pending
    test_name = "nmi_overdue";
    set_knobs(30, 0, 0, 70, 50);
    wait_nmi_level(1'b1, "a bus error to latch an NMI");
    n = 0;
    while (m_ret != int'(RETIRE_LIMIT) && n < 200) begin
      step_cycle();
      n++;
    end
    if (m_ret != int'(RETIRE_LIMIT)) report_timeout("the NMI to become overdue");
    set_knobs(0, 100, 0, 70, 50);
    wait_nmi_level(1'b0, "the NMI to be taken");
    settle_fencei();

    test_name = "fencei_handshake";
    set_knobs(0, 0, 100, 100, 0);
    n = 0;
    while (m_state != FENCEI_REQ && n < 20) begin
      step_cycle();
      n++;
    end
    if (m_state != FENCEI_REQ) report_timeout("the flush request");
    // The request must hold for as long as no acknowledge comes
    repeat (1 + $unsigned($random(seed)) % 8) step_cycle();
    set_knobs(0, 0, 100, 100, 100);
    step_cycle();
    check_value("done one cycle after acknowledge", 1, int'(fencei_done));
    settle_fencei();

    test_name = "nmi_priority";
    set_knobs(50, 0, 0, 70, 0);
    wait_nmi_level(1'b1, "a bus error to latch an NMI");
    set_knobs(0, 0, 100, 100, 0);
    repeat (8) step_cycle();
    check_value("flush request while NMI pending", 0, int'(fencei_flush_req));
    set_knobs(0, 100, 100, 100, 0);
    wait_nmi_level(1'b0, "the NMI to be taken");
    set_knobs(0, 0, 100, 100, 0);
    n = 0;
    while (m_state != FENCEI_REQ && n < 20) begin
      step_cycle();
      n++;
    end
    check_value("cycles from NMI clear to request", 1, n);
    settle_fencei();

    test_name = "mixed";
    set_knobs(10, 10, 50, 60, 50);
    repeat (300) step_cycle();

    $display("Everything OK");
    $finish;
  end

endmodule
